//--- hdl/apb_pkg.sv
// apb bus widths and the master request struct
`default_nettype none

package apb_pkg;

   // ----------------------------------------
   // bus widths
   // ----------------------------------------
   localparam int apb_addr_w = 6;    // byte address, 64 byte window
   localparam int apb_data_w = 32;   // amba rev 2 data bus

   // ----------------------------------------
   // master driven signals, one bundle
   // ----------------------------------------
   typedef struct packed {
      logic                  sel;     // psel, slave selected
      logic                  enable;  // penable, high in access phase
      logic                  write;   // pwrite, 1 = write
      logic [apb_addr_w-1:0] addr;    // paddr
      logic [apb_data_w-1:0] wdata;   // pwdata
   } apb_req_t;                       // 41 bits

endpackage

`default_nettype wire

//--- hdl/gpio_reg_pkg.sv
// gpio pin count, register map, register select enum, access and config structs, id value
`default_nettype none

package gpio_reg_pkg;

   localparam int num_pins = 16;  // io pins served

   // ----------------------------------------
   // register byte offsets
   // ----------------------------------------
   localparam logic [apb_pkg::apb_addr_w-1:0] off_data_out   = 6'h00;  // rw
   localparam logic [apb_pkg::apb_addr_w-1:0] off_dir        = 6'h04;  // rw, 1 = output
   localparam logic [apb_pkg::apb_addr_w-1:0] off_pin_in     = 6'h08;  // ro
   localparam logic [apb_pkg::apb_addr_w-1:0] off_int_en     = 6'h0C;  // rw
   localparam logic [apb_pkg::apb_addr_w-1:0] off_int_type   = 6'h10;  // rw, 1 = rising
   localparam logic [apb_pkg::apb_addr_w-1:0] off_int_status = 6'h14;  // read, w1c
   localparam logic [apb_pkg::apb_addr_w-1:0] off_id         = 6'h18;  // ro

   // block id, upper half tags the family, low half the pin count
   localparam logic [apb_pkg::apb_data_w-1:0] gpio_id = 32'h6A10_0016;

   // decoded register, sel_none for holes in the map
   typedef enum logic [2:0] {
      sel_none,
      sel_data_out,
      sel_dir,
      sel_pin_in,
      sel_int_en,
      sel_int_type,
      sel_int_status,
      sel_id
   } reg_sel_e;

   // ----------------------------------------
   // one register access, valid one cycle
   // ----------------------------------------
   typedef struct packed {
      logic                wr;     // access phase of a write
      logic                rd;     // setup phase of a read
      reg_sel_e            sel;    // target register
      logic [num_pins-1:0] wdata;  // low half of pwdata
   } reg_access_t;                 // 21 bits

   // software configuration, held in the regfile
   typedef struct packed {
      logic [num_pins-1:0] data_out;  // pin output value
      logic [num_pins-1:0] dir;       // 1 = drive pin
      logic [num_pins-1:0] int_en;    // per pin irq enable
      logic [num_pins-1:0] int_type;  // 1 = rising, 0 = falling
   } gpio_cfg_t;                      // 64 bits

endpackage

`default_nettype wire

//--- hdl/gpio_apb_port.sv
// apb slave port: address decode, access strobes, read mux and registered read data
`timescale 1ns/1ps
`default_nettype none

module gpio_apb_port
(
   input  wire                                   pclk,
   input  wire                                   arst_n,
   input  wire apb_pkg::apb_req_t                apb_req,     // from master
   input  wire gpio_reg_pkg::gpio_cfg_t          cfg,         // config readback
   input  wire [gpio_reg_pkg::num_pins-1:0]      pin_sync,    // synchronized pins
   input  wire [gpio_reg_pkg::num_pins-1:0]      int_status,  // sticky irq bits
   output gpio_reg_pkg::reg_access_t             access,      // strobe to regs
   output logic [apb_pkg::apb_data_w-1:0]        prdata       // registered read data
);

   gpio_reg_pkg::reg_sel_e                 sel;      // decoded register
   logic [gpio_reg_pkg::num_pins-1:0]      rd_val;   // selected pin wide value
   logic [apb_pkg::apb_data_w-1:0]         rd_word;  // padded to bus width

   // ----------------------------------------
   // address decode
   // ----------------------------------------
   always_comb
   begin
      case (apb_req.addr)
         gpio_reg_pkg::off_data_out:   sel = gpio_reg_pkg::sel_data_out;
         gpio_reg_pkg::off_dir:        sel = gpio_reg_pkg::sel_dir;
         gpio_reg_pkg::off_pin_in:     sel = gpio_reg_pkg::sel_pin_in;
         gpio_reg_pkg::off_int_en:     sel = gpio_reg_pkg::sel_int_en;
         gpio_reg_pkg::off_int_type:   sel = gpio_reg_pkg::sel_int_type;
         gpio_reg_pkg::off_int_status: sel = gpio_reg_pkg::sel_int_status;
         gpio_reg_pkg::off_id:         sel = gpio_reg_pkg::sel_id;
         default:                      sel = gpio_reg_pkg::sel_none;  // hole in map
      endcase
   end

   // rd in setup, wr in access; ro targets simply have no writer
   assign access.rd    = apb_req.sel & ~apb_req.enable & ~apb_req.write;
   assign access.wr    = apb_req.sel &  apb_req.enable &  apb_req.write;
   assign access.sel   = sel;
   assign access.wdata = apb_req.wdata[gpio_reg_pkg::num_pins-1:0];  // upper bits dropped

   // ----------------------------------------
   // read mux
   // ----------------------------------------
   always_comb
   begin
      case (sel)
         gpio_reg_pkg::sel_data_out:   rd_val = cfg.data_out;
         gpio_reg_pkg::sel_dir:        rd_val = cfg.dir;
         gpio_reg_pkg::sel_pin_in:     rd_val = pin_sync;
         gpio_reg_pkg::sel_int_en:     rd_val = cfg.int_en;
         gpio_reg_pkg::sel_int_type:   rd_val = cfg.int_type;
         gpio_reg_pkg::sel_int_status: rd_val = int_status;
         default:                      rd_val = '0;
      endcase
      rd_word = '0;                                   // upper half reads 0
      rd_word[gpio_reg_pkg::num_pins-1:0] = rd_val;
      if (sel == gpio_reg_pkg::sel_id)
         rd_word = gpio_reg_pkg::gpio_id;             // only full width register
   end

   // captured at end of setup, stable through access
   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
         prdata <= '0;
      else if (access.rd)
         prdata <= rd_word;
   end

endmodule

`default_nettype wire

//--- hdl/gpio_regfile.sv
// gpio configuration registers and pin output / output enable drive
`timescale 1ns/1ps
`default_nettype none

module gpio_regfile
(
   input  wire                                   pclk,
   input  wire                                   arst_n,
   input  wire gpio_reg_pkg::reg_access_t        access,            // from apb port
   input  wire [gpio_reg_pkg::num_pins-1:0]      tri_state_enable,  // test mode, forces z
   output gpio_reg_pkg::gpio_cfg_t               cfg,               // to readback and irq
   output logic [gpio_reg_pkg::num_pins-1:0]     gpio_pin_out,      // to pads
   output logic [gpio_reg_pkg::num_pins-1:0]     n_gpio_pin_oe      // active low oe
);

   logic [gpio_reg_pkg::num_pins-1:0] data_out_q;  // pin value
   logic [gpio_reg_pkg::num_pins-1:0] dir_q;       // 1 = output
   logic [gpio_reg_pkg::num_pins-1:0] int_en_q;    // irq enable
   logic [gpio_reg_pkg::num_pins-1:0] int_type_q;  // edge select

   // ----------------------------------------
   // register writes
   // ----------------------------------------
   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         data_out_q <= '0;
         dir_q      <= '0;   // all inputs out of reset
         int_en_q   <= '0;
         int_type_q <= '0;
      end
      else if (access.wr)
      begin
         // one target per access, others hold
         case (access.sel)
            gpio_reg_pkg::sel_data_out: data_out_q <= access.wdata;
            gpio_reg_pkg::sel_dir:      dir_q      <= access.wdata;
            gpio_reg_pkg::sel_int_en:   int_en_q   <= access.wdata;
            gpio_reg_pkg::sel_int_type: int_type_q <= access.wdata;
            default: ;  // ro, w1c or unmapped, not ours
         endcase
      end
   end

   // config bundle out
   assign cfg.data_out = data_out_q;
   assign cfg.dir      = dir_q;
   assign cfg.int_en   = int_en_q;
   assign cfg.int_type = int_type_q;

   // ----------------------------------------
   // pad drive
   // ----------------------------------------
   assign gpio_pin_out  = data_out_q;                  // value always presented
   assign n_gpio_pin_oe = ~(dir_q & ~tri_state_enable); // test mode wins over dir

endmodule

`default_nettype wire

//--- hdl/gpio_pin_sync.sv
// two flop pin input synchronizer with a delayed copy for edge detection
`timescale 1ns/1ps
`default_nettype none

module gpio_pin_sync
(
   input  wire                                   pclk,
   input  wire                                   arst_n,
   input  wire [gpio_reg_pkg::num_pins-1:0]      pin_in,    // async from pads
   output logic [gpio_reg_pkg::num_pins-1:0]     pin_sync,  // safe to use
   output logic [gpio_reg_pkg::num_pins-1:0]     pin_prev   // pin_sync one cycle ago
);

   logic [gpio_reg_pkg::num_pins-1:0] pin_meta;  // first stage, may go metastable

   // ----------------------------------------
   // meta -> sync -> prev
   // ----------------------------------------
   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         pin_meta <= '0;
         pin_sync <= '0;
         pin_prev <= '0;
      end
      else
      begin
         pin_meta <= pin_in;
         pin_sync <= pin_meta;   // readable after 2 edges
         pin_prev <= pin_sync;   // history for edge compare
      end
   end

endmodule

`default_nettype wire

//--- hdl/gpio_edge_irq.sv
// per pin edge detect, sticky interrupt status with write 1 to clear, combined interrupt
`timescale 1ns/1ps
`default_nettype none

module gpio_edge_irq
(
   input  wire                                   pclk,
   input  wire                                   arst_n,
   input  wire gpio_reg_pkg::reg_access_t        access,      // w1c writes
   input  wire gpio_reg_pkg::gpio_cfg_t          cfg,         // int_en, int_type
   input  wire [gpio_reg_pkg::num_pins-1:0]      pin_sync,    // current value
   input  wire [gpio_reg_pkg::num_pins-1:0]      pin_prev,    // last value
   output logic [gpio_reg_pkg::num_pins-1:0]     int_status,  // sticky bits
   output logic                                  gpio_int     // to interrupt ctrl
);

   logic [gpio_reg_pkg::num_pins-1:0] rise;      // 0 -> 1
   logic [gpio_reg_pkg::num_pins-1:0] fall;      // 1 -> 0
   logic [gpio_reg_pkg::num_pins-1:0] edge_hit;  // selected edge, enabled
   logic [gpio_reg_pkg::num_pins-1:0] clr_mask;  // bits written with 1

   // ----------------------------------------
   // edge detect
   // ----------------------------------------
   assign rise = pin_sync & ~pin_prev;
   assign fall = ~pin_sync & pin_prev;

   // int_type picks polarity per pin
   assign edge_hit = ((cfg.int_type & rise) | (~cfg.int_type & fall)) & cfg.int_en;

   assign clr_mask = (access.wr && access.sel == gpio_reg_pkg::sel_int_status)
                     ? access.wdata : '0;

   // ----------------------------------------
   // sticky status
   // ----------------------------------------
   always_ff @(posedge pclk or negedge arst_n)
   begin
      if (!arst_n)
         int_status <= '0;
      else
         int_status <= (int_status & ~clr_mask) | edge_hit;  // new edge beats clear
   end

   // masked status, so disabling a pin also drops its request
   assign gpio_int = |(int_status & cfg.int_en);

endmodule

`default_nettype wire

//--- hdl/gpio_lite.sv
// gpio top level: apb port, config registers, pin synchronizer and edge interrupt block
`timescale 1ns/1ps
`default_nettype none

module gpio_lite
(
   input  wire                                   pclk,              // apb clock
   input  wire                                   arst_n,            // async, active low
   input  wire apb_pkg::apb_req_t                apb_req,           // psel .. pwdata
   output wire [apb_pkg::apb_data_w-1:0]         prdata,            // read data
   input  wire [gpio_reg_pkg::num_pins-1:0]      gpio_pin_in,       // from pads
   input  wire [gpio_reg_pkg::num_pins-1:0]      tri_state_enable,  // test mode oe kill
   output wire                                   gpio_int,          // combined irq
   output wire [gpio_reg_pkg::num_pins-1:0]      n_gpio_pin_oe,     // to pads, active low
   output wire [gpio_reg_pkg::num_pins-1:0]      gpio_pin_out       // to pads
);

   gpio_reg_pkg::reg_access_t          access;      // bus strobes
   gpio_reg_pkg::gpio_cfg_t            cfg;         // software config
   wire [gpio_reg_pkg::num_pins-1:0]   pin_sync;    // synchronized pins
   wire [gpio_reg_pkg::num_pins-1:0]   pin_prev;    // one cycle older
   wire [gpio_reg_pkg::num_pins-1:0]   int_status;  // sticky irq bits

   // ----------------------------------------
   // bus side
   // ----------------------------------------
   gpio_apb_port gpio_apb_port_i (
      .pclk       (pclk),
      .arst_n     (arst_n),
      .apb_req    (apb_req),
      .cfg        (cfg),
      .pin_sync   (pin_sync),
      .int_status (int_status),
      .access     (access),
      .prdata     (prdata)
   );

   gpio_regfile gpio_regfile_i (
      .pclk             (pclk),
      .arst_n           (arst_n),
      .access           (access),
      .tri_state_enable (tri_state_enable),
      .cfg              (cfg),
      .gpio_pin_out     (gpio_pin_out),
      .n_gpio_pin_oe    (n_gpio_pin_oe)
   );

   // ----------------------------------------
   // pin side
   // ----------------------------------------
   gpio_pin_sync gpio_pin_sync_i (
      .pclk     (pclk),
      .arst_n   (arst_n),
      .pin_in   (gpio_pin_in),
      .pin_sync (pin_sync),
      .pin_prev (pin_prev)
   );

   gpio_edge_irq gpio_edge_irq_i (
      .pclk       (pclk),
      .arst_n     (arst_n),
      .access     (access),
      .cfg        (cfg),
      .pin_sync   (pin_sync),
      .pin_prev   (pin_prev),
      .int_status (int_status),
      .gpio_int   (gpio_int)
   );

endmodule

`default_nettype wire

//--- bench/gpio_apb_tasks.svh
// apb master write and read tasks, lfsr stimulus and value check helpers
`ifndef gpio_apb_tasks_svh
`define gpio_apb_tasks_svh

// ----------------------------------------
// two phase apb master transfers
// ----------------------------------------
task automatic apb_write(input logic [apb_pkg::apb_addr_w-1:0] addr,
                         input logic [apb_pkg::apb_data_w-1:0] data);
   @(posedge pclk);                // setup phase
   apb_req.sel    <= 1'b1;
   apb_req.enable <= 1'b0;
   apb_req.write  <= 1'b1;
   apb_req.addr   <= addr;
   apb_req.wdata  <= data;
   @(posedge pclk);                // access phase
   apb_req.enable <= 1'b1;
   @(posedge pclk);                // write lands on this edge
   apb_req.sel    <= 1'b0;
   apb_req.enable <= 1'b0;
endtask

task automatic apb_read(input logic [apb_pkg::apb_addr_w-1:0] addr,
                        output logic [apb_pkg::apb_data_w-1:0] data);
   @(posedge pclk);
   apb_req.sel    <= 1'b1;
   apb_req.enable <= 1'b0;
   apb_req.write  <= 1'b0;
   apb_req.addr   <= addr;
   apb_req.wdata  <= '0;
   @(posedge pclk);                // prdata captured here
   apb_req.enable <= 1'b1;
   @(negedge pclk);
   data = prdata;                  // stable in middle of access
   @(posedge pclk);
   apb_req.sel    <= 1'b0;
   apb_req.enable <= 1'b0;
endtask

// ----------------------------------------
// stimulus source
// ----------------------------------------
// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function logic [31:0] rand_bits(input int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++)
   begin
      lfsr_state = lfsr_next(lfsr_state);   // one step per bit
      v = {v[30:0], lfsr_state[0]};
   end
   return v;
endfunction

// ----------------------------------------
// checks
// ----------------------------------------
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
   assert (actual === expected)
   else
   begin
      $display("MISMATCH at %0t ns: %s expected 0x%08h actual 0x%08h",
               $time, name, expected, actual);
      err_cnt++;
   end
endtask

task automatic read_and_check(input logic [apb_pkg::apb_addr_w-1:0] addr,
                              input string name, input logic [31:0] expected);
   logic [31:0] rd;
   apb_read(addr, rd);
   check_value(name, expected, rd);
endtask

`endif

//--- bench/tb_gpio_lite.sv
// clock, reset, dut instance, directed tests and result summary for the gpio block
`timescale 1ns/1ps
`default_nettype none

module tb_gpio_lite;

   localparam logic [31:0] exp_id = 32'h6A10_0016;  // id register contents

   logic              pclk;
   logic              arst_n;
   apb_pkg::apb_req_t apb_req;
   logic [15:0]       gpio_pin_in;
   logic [15:0]       tri_state_enable;
   wire  [31:0]       prdata;
   wire               gpio_int;
   wire  [15:0]       n_gpio_pin_oe;
   wire  [15:0]       gpio_pin_out;

   logic [31:0] lfsr_state;   // stimulus lfsr
   logic [15:0] pin_state;    // last value put on the pins
   int          err_cnt;
   int          tests_ok;
   int          tests_bad;

   gpio_lite gpio_lite_i (
      .pclk             (pclk),
      .arst_n           (arst_n),
      .apb_req          (apb_req),
      .prdata           (prdata),
      .gpio_pin_in      (gpio_pin_in),
      .tri_state_enable (tri_state_enable),
      .gpio_int         (gpio_int),
      .n_gpio_pin_oe    (n_gpio_pin_oe),
      .gpio_pin_out     (gpio_pin_out)
   );

   always #4 pclk = ~pclk;   // 8 ns period

   `include "gpio_apb_tasks.svh"

   // ----------------------------------------
   // pin and irq helpers
   // ----------------------------------------
   task automatic drive_pins(input logic [15:0] v, input int settle);
      @(posedge pclk);
      gpio_pin_in <= v;
      pin_state = v;
      repeat (settle) @(posedge pclk);   // let sync and edge logic catch up
   endtask

   task automatic wait_irq(input logic level);
      int cycles;
      cycles = 0;
      @(negedge pclk);
      while (gpio_int !== level && cycles < 50)
      begin
         @(negedge pclk);
         cycles++;
      end
      assert (gpio_int === level)
      else
      begin
         $display("timeout at %0t ns: gpio_int did not reach %0b within 50 cycles",
                  $time, level);
         err_cnt++;
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (err_cnt == errs_before)
      begin
         tests_ok++;
         $display("%s: ok", name);
      end
      else
      begin
         tests_bad++;
         $display("%s: FAILED with %0d errors", name, err_cnt - errs_before);
      end
   endtask

   // ----------------------------------------
   // directed tests
   // ----------------------------------------
   task automatic reset_values();
      int errs;
      errs = err_cnt;
      @(negedge pclk);
      check_value("n_gpio_pin_oe", 32'h0000_ffff, n_gpio_pin_oe);  // all inputs
      check_value("gpio_pin_out", 32'h0, gpio_pin_out);
      check_value("gpio_int", 32'h0, gpio_int);
      check_value("prdata", 32'h0, prdata);
      read_and_check(gpio_reg_pkg::off_data_out, "data_out", 32'h0);
      read_and_check(gpio_reg_pkg::off_dir, "dir", 32'h0);
      read_and_check(gpio_reg_pkg::off_int_en, "int_en", 32'h0);
      read_and_check(gpio_reg_pkg::off_int_type, "int_type", 32'h0);
      read_and_check(gpio_reg_pkg::off_int_status, "int_status", 32'h0);
      read_and_check(gpio_reg_pkg::off_id, "id", exp_id);
      read_and_check(6'h1c, "unmapped 0x1c", 32'h0);   // first hole past id
      read_and_check(6'h3c, "unmapped 0x3c", 32'h0);
      finish_test("reset_values", errs);
   endtask

   task automatic reg_readback();
      int          errs;
      logic [5:0]  offs [4];
      logic [15:0] vals [4];
      logic [15:0] junk;
      errs = err_cnt;
      offs[0] = gpio_reg_pkg::off_data_out;
      offs[1] = gpio_reg_pkg::off_dir;
      offs[2] = gpio_reg_pkg::off_int_en;
      offs[3] = gpio_reg_pkg::off_int_type;
      for (int i = 0; i < 4; i++)
      begin
         vals[i] = rand_bits(16);
         junk    = rand_bits(16);
         apb_write(offs[i], {junk, vals[i]});   // junk in upper half
      end
      for (int i = 0; i < 4; i++)
         read_and_check(offs[i], $sformatf("reg 0x%02h", offs[i]), {16'h0, vals[i]});
      // read only targets ignore writes
      read_and_check(gpio_reg_pkg::off_pin_in, "pin_in", {16'h0, pin_state});
      apb_write(gpio_reg_pkg::off_pin_in, rand_bits(32));
      read_and_check(gpio_reg_pkg::off_pin_in, "pin_in", {16'h0, pin_state});
      apb_write(gpio_reg_pkg::off_id, rand_bits(32));
      read_and_check(gpio_reg_pkg::off_id, "id", exp_id);
      finish_test("reg_readback", errs);
   endtask

   task automatic output_drive();
      int          errs;
      logic [15:0] dout;
      logic [15:0] dir;
      logic [15:0] tse;
      logic [15:0] exp_oe;
      errs = err_cnt;
      dout = rand_bits(16);
      dir  = rand_bits(16);
      apb_write(gpio_reg_pkg::off_data_out, dout);
      apb_write(gpio_reg_pkg::off_dir, dir);
      for (int i = 0; i < 5; i++)
      begin
         tse = (i == 0) ? 16'h0 : rand_bits(16);   // first pass with test mode off
         @(posedge pclk);
         tri_state_enable <= tse;
         @(negedge pclk);
         for (int b = 0; b < 16; b++)
            exp_oe[b] = (dir[b] && !tse[b]) ? 1'b0 : 1'b1;   // driven pins read low
         check_value("gpio_pin_out", dout, gpio_pin_out);
         check_value("n_gpio_pin_oe", exp_oe, n_gpio_pin_oe);
      end
      @(posedge pclk);
      tri_state_enable <= '0;
      finish_test("output_drive", errs);
   endtask

   task automatic input_readback();
      int          errs;
      logic [15:0] v;
      errs = err_cnt;
      apb_write(gpio_reg_pkg::off_int_en, 32'h0);   // keep irq quiet
      for (int i = 0; i < 4; i++)
      begin
         v = rand_bits(16);
         drive_pins(v, 3);
         read_and_check(gpio_reg_pkg::off_pin_in, "pin_in", {16'h0, v});
      end
      finish_test("input_readback", errs);
   endtask

   task automatic edge_interrupts();
      int          errs;
      int          pin;
      int          other;
      logic        rising;
      logic [15:0] bit_m;
      logic [15:0] type_v;
      errs = err_cnt;
      for (int n = 0; n < 6; n++)
      begin
         pin    = rand_bits(4);
         rising = rand_bits(1);
         other  = (pin + 1 + rand_bits(3)) % 16;   // never the same pin
         bit_m  = 16'h1 << pin;
         type_v = rising ? (rand_bits(16) | bit_m) : (rand_bits(16) & ~bit_m);
         apb_write(gpio_reg_pkg::off_int_en, 32'h0);
         // park the pin at the level the good edge ends on
         drive_pins(rising ? (pin_state | bit_m) : (pin_state & ~bit_m), 4);
         apb_write(gpio_reg_pkg::off_int_status, 32'hffff);
         apb_write(gpio_reg_pkg::off_int_type, type_v);
         apb_write(gpio_reg_pkg::off_int_en, bit_m);
         drive_pins(pin_state ^ bit_m, 4);         // wrong polarity
         @(negedge pclk);
         check_value("gpio_int", 32'h0, gpio_int);
         read_and_check(gpio_reg_pkg::off_int_status, "int_status", 32'h0);
         drive_pins(pin_state ^ bit_m, 0);         // matching edge
         wait_irq(1'b1);
         read_and_check(gpio_reg_pkg::off_int_status, "int_status", bit_m);
         // both edges on a disabled pin
         drive_pins(pin_state ^ (16'h1 << other), 4);
         drive_pins(pin_state ^ (16'h1 << other), 4);
         read_and_check(gpio_reg_pkg::off_int_status, "int_status", bit_m);
      end
      finish_test("edge_irq", errs);
   endtask

   task automatic write_one_to_clear();
      int          errs;
      logic [15:0] v;
      logic [15:0] m;
      logic [15:0] rem;
      errs = err_cnt;
      apb_write(gpio_reg_pkg::off_int_en, 32'h0);
      drive_pins(16'h0, 4);
      apb_write(gpio_reg_pkg::off_int_status, 32'hffff);
      apb_write(gpio_reg_pkg::off_int_type, 32'hffff);   // all rising
      apb_write(gpio_reg_pkg::off_int_en, 32'hffff);
      v = rand_bits(16) | 16'h0101;
      drive_pins(v, 0);
      wait_irq(1'b1);
      read_and_check(gpio_reg_pkg::off_int_status, "int_status", v);
      m   = (rand_bits(16) & v & ~16'h0100) | 16'h0001;   // bit 8 stays set
      rem = v & ~m;
      apb_write(gpio_reg_pkg::off_int_status, m);
      read_and_check(gpio_reg_pkg::off_int_status, "int_status", rem);
      @(negedge pclk);
      check_value("gpio_int", 32'h1, gpio_int);
      // masking the leftovers drops irq while status holds
      apb_write(gpio_reg_pkg::off_int_en, ~rem);
      wait_irq(1'b0);
      read_and_check(gpio_reg_pkg::off_int_status, "int_status", rem);
      apb_write(gpio_reg_pkg::off_int_en, 32'hffff);
      wait_irq(1'b1);
      apb_write(gpio_reg_pkg::off_int_status, rem);
      wait_irq(1'b0);
      read_and_check(gpio_reg_pkg::off_int_status, "int_status", 32'h0);
      finish_test("write_1_to_clear", errs);
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial
   begin
      pclk             = 1'b0;
      arst_n           = 1'b0;
      apb_req          = '0;
      gpio_pin_in      = '0;
      tri_state_enable = '0;
      lfsr_state       = 32'h25d2;
      pin_state        = '0;
      err_cnt          = 0;
      tests_ok         = 0;
      tests_bad        = 0;
      repeat (10) @(posedge pclk);
      arst_n <= 1'b1;
      reset_values();
      reg_readback();
      output_drive();
      input_readback();
      edge_interrupts();
      write_one_to_clear();
      $display("summary: %0d tests ok, %0d tests failed, %0d check errors",
               tests_ok, tests_bad, err_cnt);
      if (tests_bad == 0 && err_cnt == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- gpio_lite.f
+incdir+bench
hdl/apb_pkg.sv
hdl/gpio_reg_pkg.sv
hdl/gpio_apb_port.sv
hdl/gpio_regfile.sv
hdl/gpio_pin_sync.sv
hdl/gpio_edge_irq.sv
hdl/gpio_lite.sv
bench/tb_gpio_lite.sv
